//--- corr_stream_pkg.sv
/*
  Stream geometry and beat layouts for the correlator.
  NUM_CH must be a power of two, since the channel counter wraps freely.
  ACC_W covers up to MAX_TAPS taps of SAMPLE_W-bit samples without overflow.
  Channel 0 occupies the low bits of every beat.
*/
`default_nettype none

package corr_stream_pkg;

  // geometry
  localparam int NUM_CH   = 8;
  localparam int CH_W     = $clog2(NUM_CH);
  localparam int SAMPLE_W = 8;
  localparam int ACC_W    = 16;
  localparam int MAX_TAPS = 32;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // one signed sample per channel
  typedef sample_t [NUM_CH-1:0] in_beat_t;

  // one signed correlation sum per channel
  typedef acc_t [NUM_CH-1:0] out_beat_t;

endpackage

`default_nettype wire

//--- corr_cfg_pkg.sv
/*
  Register map and Wishbone classic bus records for the config port.
  Word addressed, 32-bit data, byte lanes selected by sel.
*/
`default_nettype none

package corr_cfg_pkg;

  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = WB_DAT_W / 8;

  // word offsets
  localparam logic [1:0] REG_TAPS  = 2'd0;
  localparam logic [1:0] REG_CTRL  = 2'd1;
  localparam logic [1:0] REG_BEATS = 2'd2;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [1:0]          adr;
    logic [WB_DAT_W-1:0] dat;
    logic [WB_SEL_W-1:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- corr_stream_reg.sv
/*
  Single-entry valid/ready register slice for any packed payload.
  Accepts while empty or while its entry leaves, so full throughput.
  in_ready stays low for the first cycle out of reset.
*/
`timescale 1ns/1ps
`default_nettype none

module corr_stream_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     live_q;
  logic     full_q;
  payload_t data_q;

  assign in_ready = live_q && (!full_q || out_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      live_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      // otherwise full and stalled, or not yet live
      if (in_ready) begin
        full_q <= in_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full_q;
  assign out_data  = data_q;

endmodule

`default_nettype wire

//--- corr_chan_seq.sv
/*
  Walks the channels of one held beat through the shared adder chain.
  A beat starts only while the output slice is free; out_load then holds
  until the slice takes it, so no result is lost under back-pressure.
  The input beat is released on the last channel step.
*/
`timescale 1ns/1ps
`default_nettype none

module corr_chan_seq
  import corr_stream_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            beat_valid,
  output logic            beat_ready,
  input  logic            out_free,
  output logic            step,
  output logic [CH_W-1:0] chan,
  output logic            out_load
);

  localparam logic [CH_W-1:0] LAST_CH = CH_W'(NUM_CH - 1);

  logic            busy_q;
  logic            load_q;
  logic [CH_W-1:0] chan_q;
  logic            last_step;

  assign last_step = busy_q && (chan_q == LAST_CH);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      load_q <= 1'b0;
      chan_q <= '0;
    end else if (busy_q) begin
      // counter wraps back to channel 0 after the last step
      chan_q <= chan_q + CH_W'(1);
      if (last_step) begin
        busy_q <= 1'b0;
        load_q <= 1'b1;
      end
    end else if (out_free) begin
      // pending result leaves, next beat may start in the same cycle
      load_q <= 1'b0;
      busy_q <= beat_valid;
    end
  end

  assign beat_ready = last_step;
  assign step       = busy_q;
  assign chan       = chan_q;
  assign out_load   = load_q;

endmodule

`default_nettype wire

//--- corr_tap_chain.sv
/*
  Time-multiplexed bipolar adder chain, one channel per step.
  Stage k adds or subtracts the sample against the partial sum that
  stage k-1 left for the same channel. History is a register array.
  Sums wrap at ACC_W, no saturation. NUM_TAPS from 2 to MAX_TAPS.
*/
`timescale 1ns/1ps
`default_nettype none

module corr_tap_chain
  import corr_stream_pkg::*;
#(
  parameter int NUM_TAPS = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                clear,
  input  logic                step,
  input  logic [CH_W-1:0]     chan,
  input  in_beat_t            beat,
  input  logic [MAX_TAPS-1:0] tap_signs,
  output out_beat_t           result
);

  // partial sums of stages 0 .. NUM_TAPS-2, per channel
  acc_t      hist_q [NUM_TAPS-1][NUM_CH];
  out_beat_t result_q;
  sample_t   sample;
  acc_t      sample_ext;
  acc_t      stage_in  [NUM_TAPS];
  acc_t      stage_sum [NUM_TAPS];

  assign sample     = beat[chan];
  assign sample_ext = {{(ACC_W-SAMPLE_W){sample[SAMPLE_W-1]}}, sample};

  ////////////////////////////////////////////////////////////
  // stage links and add/subtract
  ////////////////////////////////////////////////////////////

  assign stage_in[0] = '0;

  for (genvar k = 1; k < NUM_TAPS; k++) begin : g_link
    assign stage_in[k] = hist_q[k-1][chan];
  end

  // sign bit 1 adds, 0 subtracts
  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_stage
    assign stage_sum[k] = tap_signs[k] ? stage_in[k] + sample_ext
                                       : stage_in[k] - sample_ext;
  end

  ////////////////////////////////////////////////////////////
  // history and result storage
  ////////////////////////////////////////////////////////////

  // clear wins over a step in the same cycle
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        for (int c = 0; c < NUM_CH; c++) begin
          hist_q[k][c] <= '0;
        end
      end
    end else if (step) begin
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        hist_q[k][chan] <= stage_sum[k];
      end
    end
  end

  // last stage lands in the channel slot, held until that channel steps again
  always_ff @(posedge clk) begin
    if (step && !clear) begin
      result_q[chan] <= stage_sum[NUM_TAPS-1];
    end
  end

  assign result = result_q;

endmodule

`default_nettype wire

//--- corr_tap_regs.sv
/*
  Wishbone classic slave for the correlator config.
  Ack comes one cycle after cyc/stb and lasts one cycle; writes land on that edge.
  Tap sign bits at and above NUM_TAPS are forced to zero.
  CTRL bit 0 gives a one-cycle history clear; REG_BEATS wraps at 2^32.
*/
`timescale 1ns/1ps
`default_nettype none

module corr_tap_regs
  import corr_stream_pkg::*, corr_cfg_pkg::*;
#(
  parameter int NUM_TAPS = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  wb_req_t             wb_i,
  output wb_rsp_t             wb_o,
  input  logic                out_fire,
  output logic [MAX_TAPS-1:0] tap_signs,
  output logic                clear
);

  localparam logic [MAX_TAPS-1:0] TAP_MASK = {MAX_TAPS{1'b1}} >> (MAX_TAPS - NUM_TAPS);

  logic                ack_q;
  logic [WB_DAT_W-1:0] rdat_q;
  logic [MAX_TAPS-1:0] taps_q;
  logic [31:0]         beats_q;
  logic                clear_q;
  logic                access;
  logic                wr_done;
  logic [WB_DAT_W-1:0] lane_mask;
  logic [WB_DAT_W-1:0] rd_mux;

  // new request seen, ack not yet given
  assign access  = wb_i.cyc && wb_i.stb && !ack_q;
  assign wr_done = ack_q && wb_i.cyc && wb_i.stb && wb_i.we;

  always_comb begin
    for (int i = 0; i < WB_SEL_W; i++) begin
      lane_mask[8*i +: 8] = {8{wb_i.sel[i]}};
    end
  end

  // CTRL and the unused word read as zero
  always_comb begin
    case (wb_i.adr)
      REG_TAPS:  rd_mux = WB_DAT_W'(taps_q);
      REG_BEATS: rd_mux = beats_q;
      default:   rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q   <= 1'b0;
      clear_q <= 1'b0;
      taps_q  <= TAP_MASK;
      beats_q <= '0;
    end else begin
      ack_q   <= access;
      clear_q <= wr_done && (wb_i.adr == REG_CTRL) && wb_i.sel[0] && wb_i.dat[0];
      if (wr_done && (wb_i.adr == REG_TAPS)) begin
        taps_q <= MAX_TAPS'((WB_DAT_W'(taps_q) & ~lane_mask) | (wb_i.dat & lane_mask))
                  & TAP_MASK;
      end
      if (out_fire) begin
        beats_q <= beats_q + 32'd1;
      end
    end
  end

  // read data captured with the ack
  always_ff @(posedge clk) begin
    if (access) begin
      rdat_q <= rd_mux;
    end
  end

  assign wb_o      = '{ack: ack_q, dat: rdat_q};
  assign tap_signs = taps_q;
  assign clear     = clear_q;

endmodule

`default_nettype wire

//--- corr_top.sv
/*
  Bipolar correlator top: input slice, channel sequencer, adder chain,
  output slice and Wishbone config block. Single clock, sync reset.
  One beat per NUM_CH+1 cycles when not stalled.
  Tap signs should change only while the stream is idle.
*/
`timescale 1ns/1ps
`default_nettype none

module corr_top
  import corr_stream_pkg::*, corr_cfg_pkg::*;
#(
  parameter int NUM_TAPS = 16
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      s_valid,
  output logic      s_ready,
  input  in_beat_t  s_data,
  output logic      m_valid,
  input  logic      m_ready,
  output out_beat_t m_data,
  input  wb_req_t   wb_i,
  output wb_rsp_t   wb_o
);

  in_beat_t            beat;
  logic                beat_valid;
  logic                beat_ready;
  logic                out_free;
  logic                out_load;
  logic                step;
  logic [CH_W-1:0]     chan;
  out_beat_t           result;
  logic [MAX_TAPS-1:0] tap_signs;
  logic                clear;
  logic                m_fire;

  assign m_fire = m_valid && m_ready;

  corr_stream_reg #(.payload_t(in_beat_t)) u_in_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .in_data   (s_data),
    .out_valid (beat_valid),
    .out_ready (beat_ready),
    .out_data  (beat)
  );

  corr_chan_seq u_seq (
    .clk        (clk),
    .rst        (rst),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .out_free   (out_free),
    .step       (step),
    .chan       (chan),
    .out_load   (out_load)
  );

  corr_tap_chain #(.NUM_TAPS(NUM_TAPS)) u_chain (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .step      (step),
    .chan      (chan),
    .beat      (beat),
    .tap_signs (tap_signs),
    .result    (result)
  );

  corr_stream_reg #(.payload_t(out_beat_t)) u_out_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (out_load),
    .in_ready  (out_free),
    .in_data   (result),
    .out_valid (m_valid),
    .out_ready (m_ready),
    .out_data  (m_data)
  );

  corr_tap_regs #(.NUM_TAPS(NUM_TAPS)) u_regs (
    .clk       (clk),
    .rst       (rst),
    .wb_i      (wb_i),
    .wb_o      (wb_o),
    .out_fire  (m_fire),
    .tap_signs (tap_signs),
    .clear     (clear)
  );

endmodule

`default_nettype wire

//--- corr_checker.sv
/*
  Protocol assertions for corr_top, attached by bind.
  Covers output stream hold rules and the Wishbone ack shape.
  All properties are disabled during reset.
*/
`timescale 1ns/1ps
`default_nettype none

module corr_checker
  import corr_stream_pkg::*, corr_cfg_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      m_valid,
  input logic      m_ready,
  input out_beat_t m_data,
  input wb_req_t   wb_i,
  input wb_rsp_t   wb_o
);

  // stalled output keeps valid and data
  m_hold: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("m_valid dropped or m_data changed before m_ready");

  ack_single: assert property (@(posedge clk) disable iff (rst)
    wb_o.ack |=> !wb_o.ack)
    else $error("wb ack held for more than one cycle");

  ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
    wb_o.ack |-> wb_i.cyc && wb_i.stb)
    else $error("wb ack raised without cyc and stb");

endmodule

bind corr_top corr_checker i_checker (
  .clk     (clk),
  .rst     (rst),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data),
  .wb_i    (wb_i),
  .wb_o    (wb_o)
);

`default_nettype wire

//--- tb_clock_gen.sv
/*
  Testbench clock and reset source.
  Reset is released on a falling edge, after RESET_CYCLES rising edges.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_corr_top.sv
/*
  Testbench for corr_top. Inputs change on the falling clock edge only.
  Expected beats come from a per-channel sample history model.
  Tap changes are always followed by a history clear, since stored
  partial sums keep the signs they were built with.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_corr_top
  import corr_stream_pkg::*, corr_cfg_pkg::*;
;

  localparam int NUM_TAPS = 16;
  localparam logic [31:0] TAP_MASK = 32'((64'd1 << NUM_TAPS) - 64'd1);

  localparam int B_ONES      = 24;
  localparam int B_RAND      = 80;
  localparam int B_STALL     = 120;
  localparam int B_CLEAR     = 28;
  localparam int TOTAL_BEATS = B_ONES + B_RAND + B_STALL + B_CLEAR;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * (NUM_CH + 3) * 4 + 2000;

  logic      clk;
  logic      rst;
  logic      s_valid;
  logic      s_ready;
  in_beat_t  s_data;
  logic      m_valid;
  logic      m_ready;
  out_beat_t m_data;
  wb_req_t   wb_i;
  wb_rsp_t   wb_o;

  logic                stall_mode;
  logic [MAX_TAPS-1:0] taps_model;
  sample_t             hist [NUM_CH][NUM_TAPS];
  out_beat_t           exp_q [$];
  int                  beats_seen   = 0;
  int                  value_errors = 0;
  int                  other_errors = 0;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(16)) u_clk (
    .clk (clk),
    .rst (rst)
  );

  corr_top #(.NUM_TAPS(NUM_TAPS)) i_dut (
    .clk     (clk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .wb_i    (wb_i),
    .wb_o    (wb_o)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic void clear_history();
    for (int c = 0; c < NUM_CH; c++) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        hist[c][k] = '0;
      end
    end
  endfunction

  // hist[c][0] is the newest sample; s_k pairs with hist index NUM_TAPS-1-k
  function automatic out_beat_t expected_beat(input in_beat_t x);
    out_beat_t y;
    int        sum;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int k = NUM_TAPS - 1; k > 0; k--) begin
        hist[c][k] = hist[c][k-1];
      end
      hist[c][0] = x[c];
      sum = 0;
      for (int k = 0; k < NUM_TAPS; k++) begin
        if (taps_model[k]) begin
          sum += int'(hist[c][NUM_TAPS-1-k]);
        end else begin
          sum -= int'(hist[c][NUM_TAPS-1-k]);
        end
      end
      y[c] = acc_t'(sum);
    end
    return y;
  endfunction

  function automatic in_beat_t random_beat();
    in_beat_t b;
    for (int c = 0; c < NUM_CH; c++) begin
      b[c] = sample_t'($urandom());
    end
    return b;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus and stream tasks, all entered and left on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input logic [1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    wb_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hf};
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_o.ack && waited < 16);
    if (!wb_o.ack) begin
      other_errors++;
      $display("bus access to word %0d got no ack at %0t", adr, $time);
    end
    rdat = wb_o.dat;
    // hold through the ack edge, where the write lands
    @(negedge clk);
    wb_i = '0;
  endtask

  task automatic write_reg(input logic [1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic check_reg(input logic [1:0] adr, input logic [31:0] want,
                           input string name);
    logic [31:0] got;
    wb_access(1'b0, adr, 32'd0, got);
    assert (got == want) else begin
      value_errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, want, got);
    end
  endtask

  // new signs, then a history clear in the DUT and the model
  task automatic set_taps(input logic [31:0] word);
    write_reg(REG_TAPS, word);
    taps_model = word & TAP_MASK;
    check_reg(REG_TAPS, word & TAP_MASK, "REG_TAPS");
    write_reg(REG_CTRL, 32'd1);
    clear_history();
  endtask

  task automatic send_beat(input in_beat_t x);
    logic taken;
    s_valid = 1'b1;
    s_data  = x;
    taken   = 1'b0;
    while (!taken) begin
      taken = s_ready;
      @(negedge clk);
    end
    s_valid = 1'b0;
    exp_q.push_back(expected_beat(x));
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // output side: ready pattern and comparison
  ////////////////////////////////////////////////////////////

  initial begin : out_check
    out_beat_t want;
    m_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (rst) begin
        m_ready = 1'b0;
      end else if (stall_mode) begin
        m_ready = ($urandom_range(0, 2) != 0);
      end else begin
        m_ready = 1'b1;
      end
      // both held until the next rising edge, so this is a transfer
      if (m_valid && m_ready) begin
        beats_seen++;
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("output beat at %0t with no input beat left to match", $time);
        end else begin
          want = exp_q.pop_front();
          assert (m_data == want) else begin
            value_errors++;
            $display("** Error at %0t: m_data expected %h, got %h", $time, want, m_data);
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    s_valid    = 1'b0;
    s_data     = '0;
    wb_i       = '0;
    stall_mode = 1'b0;
    taps_model = TAP_MASK;
    clear_history();
    void'($urandom(32'h2ccd));
    wait (rst == 1'b0);
    @(negedge clk);

    // taps come out of reset all ones, so a plain running sum
    check_reg(REG_TAPS, TAP_MASK, "REG_TAPS");
    repeat (B_ONES) send_beat(random_beat());
    wait_drained();

    // register access
    set_taps($urandom());
    check_reg(REG_CTRL, 32'd0, "REG_CTRL");

    // random signs, idle between sign changes
    repeat (4) begin
      set_taps($urandom());
      repeat (B_RAND / 4) send_beat(random_beat());
      wait_drained();
    end

    // input gaps and output stalls
    stall_mode = 1'b1;
    repeat (B_STALL) begin
      repeat ($urandom_range(0, 3)) @(negedge clk);
      send_beat(random_beat());
    end
    wait_drained();
    stall_mode = 1'b0;
    check_reg(REG_BEATS, 32'(beats_seen), "REG_BEATS");

    // clear with history already filled
    write_reg(REG_CTRL, 32'd1);
    clear_history();
    check_reg(REG_CTRL, 32'd0, "REG_CTRL");
    repeat (B_CLEAR) send_beat(random_beat());
    wait_drained();

    if (beats_seen != TOTAL_BEATS) begin
      other_errors++;
      $display("saw %0d output beats, sent %0d", beats_seen, TOTAL_BEATS);
    end
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- corr.f
corr_stream_pkg.sv
corr_cfg_pkg.sv
corr_stream_reg.sv
corr_chan_seq.sv
corr_tap_chain.sv
corr_tap_regs.sv
corr_top.sv
corr_checker.sv
tb_clock_gen.sv
tb_corr_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_corr_top
FILELIST = corr.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Result: FAILED
PASS_MSG = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
